//--- src/int_mem_pkg.sv
package int_mem_pkg;

   // word and address widths
   localparam int DATA_W     = 32;
   localparam int RAM_ADDR_W = 8;
   localparam int ROM_ADDR_W = 4;

   localparam int STRB_W    = DATA_W / 8;
   localparam int RAM_DEPTH = 2 ** RAM_ADDR_W;
   localparam int ROM_DEPTH = 2 ** ROM_ADDR_W;

   // last rom word, where the copy counter stops
   localparam logic [ROM_ADDR_W-1:0] ROM_LAST = ROM_ADDR_W'(ROM_DEPTH - 1);

   // boot code sits in the top words of the ram
   localparam logic [RAM_ADDR_W-1:0] BOOT_BASE = RAM_ADDR_W'(RAM_DEPTH - ROM_DEPTH);

   typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

   typedef logic [ROM_ADDR_W-1:0] rom_addr_t;

   typedef logic [DATA_W-1:0] data_t;

   typedef logic [STRB_W-1:0] strb_t;

   // storage word, read whole or written per byte lane
   typedef union packed {
      data_t                  word;
      logic [STRB_W-1:0][7:0] bytes;
   } ram_word_u;

endpackage

//--- src/mem_port_if.sv
`timescale 1ns/10ps

// one access per valid cycle, ready one cycle later
interface mem_port_if import int_mem_pkg::*; ();

   logic      valid;
   ram_addr_t addr;
   data_t     wdata;
   strb_t     wstrb;
   data_t     rdata;
   logic      ready;

   modport requester (
      output valid,
      output addr,
      output wdata,
      output wstrb,
      input  rdata,
      input  ready
   );

   modport ram (
      input  valid,
      input  addr,
      input  wdata,
      input  wstrb,
      output rdata,
      output ready
   );

endinterface

//--- src/boot_rom.sv
`timescale 1ns/10ps

module boot_rom import int_mem_pkg::*; (
   input  logic      clk,
   input  logic      i_en,
   input  rom_addr_t i_addr,
   output data_t     o_data
);

   data_t rom [ROM_DEPTH];

   // contents fixed at start
   initial begin
      $readmemh("src/boot_rom.hex", rom);
   end

   // registered read, data one cycle after the address
   always_ff @(posedge clk) begin
      if (i_en) begin
         o_data <= rom[i_addr];
      end
   end

endmodule

//--- src/boot_copier.sv
`timescale 1ns/10ps

module boot_copier import int_mem_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      i_boot,
   output rom_addr_t o_rom_addr,
   output logic      o_rom_en,
   output rom_addr_t o_copy_addr,
   output logic      o_copy_active,
   output logic      o_copy_settled,
   output logic      o_done
);

   rom_addr_t  rom_addr_q;
   rom_addr_t  copy_addr_q;
   logic [2:0] done_q;
   logic       at_last;

   assign at_last = (rom_addr_q == ROM_LAST);

   // walk the rom once, then push done through three stages
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rom_addr_q  <= '0;
         copy_addr_q <= '0;
         done_q      <= '0;
      end else if (i_boot) begin
         // write address trails the read by the rom latency
         copy_addr_q <= rom_addr_q;
         done_q[2:1] <= done_q[1:0];
         if (!at_last) begin
            rom_addr_q <= rom_addr_q + 1'b1;
         end else begin
            done_q[0] <= 1'b1;
         end
      end else begin
         // no boot, nothing to copy
         done_q <= '1;
      end
   end

   assign o_rom_addr     = rom_addr_q;
   assign o_rom_en       = ~done_q[0];
   assign o_copy_addr    = copy_addr_q;
   assign o_copy_active  = ~done_q[0];
   assign o_copy_settled = done_q[1];
   assign o_done         = done_q[2];

   // once the first done stage is set the counter never moves again
   a_counter_hold: assert property (
      @(posedge clk) disable iff (rst)
      done_q[0] |=> $stable(rom_addr_q)
   );

endmodule

//--- src/dual_port_ram.sv
`timescale 1ns/10ps

module dual_port_ram import int_mem_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   mem_port_if.ram   port,
   input  ram_addr_t i_i_addr,
   input  strb_t     i_i_en,
   output data_t     o_i_data,
   output logic      o_i_ready
);

   ram_word_u mem [RAM_DEPTH];
   ram_word_u wr_word;
   logic      wr_en;
   logic      rd_en;
   logic      i_rd_en;

   // write data split into byte lanes
   always_comb begin
      wr_word.word = port.wdata;
   end

   assign wr_en   = port.valid && (port.wstrb != '0);
   assign rd_en   = port.valid && (port.wstrb == '0);
   assign i_rd_en = |i_i_en;

   // byte merge under the strobe
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (port.wstrb[b]) begin
               mem[port.addr].bytes[b] <= wr_word.bytes[b];
            end
         end
      end
   end

   // data port read
   always_ff @(posedge clk) begin
      if (rd_en) begin
         port.rdata <= mem[port.addr].word;
      end
   end

   // instruction port read, sees the word from before a same-cycle write
   always_ff @(posedge clk) begin
      if (i_rd_en) begin
         o_i_data <= mem[i_i_addr].word;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         port.ready <= 1'b0;
         o_i_ready  <= 1'b0;
      end else begin
         port.ready <= port.valid;
         o_i_ready  <= i_rd_en;
      end
   end

   // each ready answers a request from the cycle before
   a_data_ready: assert property (
      @(posedge clk) disable iff (rst)
      port.ready |-> $past(port.valid)
   );

   a_instr_ready: assert property (
      @(posedge clk) disable iff (rst)
      o_i_ready |-> $past(i_i_en != '0)
   );

endmodule

//--- src/int_mem.sv
`timescale 1ns/10ps

module int_mem import int_mem_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      i_boot,
   // instruction port
   input  ram_addr_t i_i_addr,
   input  strb_t     i_i_en,
   output data_t     o_i_data,
   output logic      o_i_ready,
   // data port
   input  logic      i_valid,
   input  ram_addr_t i_addr,
   input  data_t     i_wdata,
   input  strb_t     i_wstrb,
   output logic      o_ready,
   output data_t     o_rdata
);

   rom_addr_t rom_addr;
   logic      rom_en;
   data_t     rom_data;
   rom_addr_t copy_addr;
   logic      copy_active;
   logic      copy_settled;
   logic      boot_done;
   ram_addr_t addr_offset;
   ram_addr_t ram_i_addr;
   strb_t     ram_i_en;
   logic      ram_i_ready;

   mem_port_if dport ();

   boot_copier copier_i (
      .clk            (clk),
      .rst            (rst),
      .i_boot         (i_boot),
      .o_rom_addr     (rom_addr),
      .o_rom_en       (rom_en),
      .o_copy_addr    (copy_addr),
      .o_copy_active  (copy_active),
      .o_copy_settled (copy_settled),
      .o_done         (boot_done)
   );

   boot_rom rom_i (
      .clk    (clk),
      .i_en   (rom_en),
      .i_addr (rom_addr),
      .o_data (rom_data)
   );

   // cpu sees the boot code at address 0 while boot is high
   assign addr_offset = i_boot ? BOOT_BASE : '0;

   // copy writes own the data port until the last rom word has landed
   always_comb begin
      if (!copy_settled) begin
         dport.valid = i_boot;
         dport.addr  = ram_addr_t'(copy_addr) + BOOT_BASE;
         dport.wdata = rom_data;
         dport.wstrb = '1;
      end else begin
         dport.valid = i_valid && boot_done;
         dport.addr  = i_addr + addr_offset;
         dport.wdata = i_wdata;
         dport.wstrb = i_wstrb;
      end
   end

   // instruction fetches before done are dropped
   assign ram_i_addr = i_i_addr + addr_offset;
   assign ram_i_en   = boot_done ? i_i_en : '0;

   dual_port_ram ram_i (
      .clk       (clk),
      .rst       (rst),
      .port      (dport.ram),
      .i_i_addr  (ram_i_addr),
      .i_i_en    (ram_i_en),
      .o_i_data  (o_i_data),
      .o_i_ready (ram_i_ready)
   );

   assign o_ready   = boot_done && dport.ready;
   assign o_i_ready = boot_done && ram_i_ready;
   assign o_rdata   = dport.rdata;

   // a ready only answers a request accepted after done
   a_ready_after_done: assert property (
      @(posedge clk) disable iff (rst)
      (o_ready || o_i_ready) |-> $past(boot_done)
   );

   // every rom read turns into a full-word write one cycle later
   a_copy_write: assert property (
      @(posedge clk) disable iff (rst)
      copy_active && i_boot ##1 i_boot |-> dport.valid && (dport.wstrb == '1)
   );

endmodule

//--- dv/int_mem_checks.svh
`ifndef INT_MEM_CHECKS_SVH
`define INT_MEM_CHECKS_SVH

// instruction port data
task automatic compare_data(input string name, input data_t got, input data_t exp);
   if (got !== exp) begin
      abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
   end
endtask

// data port read data
task automatic compare_rdata(input data_t got, input data_t exp);
   if (got !== exp) begin
      abort_run($sformatf("ERR o_rdata got 0x%h expected 0x%h", got, exp));
   end
endtask

// ready strobes
task automatic compare_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
   end
endtask

`endif

//--- dv/int_mem_tb.sv
`timescale 1ns/10ps

module int_mem_tb import int_mem_pkg::*; ();

   localparam int CLK_PERIOD = 4;
   localparam int BOOT_LIMIT = ROM_DEPTH + 8;
   localparam int N_RANDOM   = 1200;
   localparam int N_LOW      = 600;
   localparam int N_OPS      = 5 + BOOT_LIMIT + RAM_DEPTH + 2 * ROM_DEPTH + N_RANDOM + N_LOW + 2;

   logic      clk;
   logic      rst;
   logic      i_boot;
   ram_addr_t i_i_addr;
   strb_t     i_i_en;
   data_t     o_i_data;
   logic      o_i_ready;
   logic      i_valid;
   ram_addr_t i_addr;
   data_t     i_wdata;
   strb_t     i_wstrb;
   logic      o_ready;
   data_t     o_rdata;

   // reference model and the response expected at the next falling edge
   data_t model [RAM_DEPTH];
   data_t rom_words [ROM_DEPTH];
   logic  exp_ready;
   logic  exp_i_ready;
   logic  chk_rdata;
   data_t exp_rdata;
   data_t exp_i_data;

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   int_mem int_mem_i (
      .clk       (clk),
      .rst       (rst),
      .i_boot    (i_boot),
      .i_i_addr  (i_i_addr),
      .i_i_en    (i_i_en),
      .o_i_data  (o_i_data),
      .o_i_ready (o_i_ready),
      .i_valid   (i_valid),
      .i_addr    (i_addr),
      .i_wdata   (i_wdata),
      .i_wstrb   (i_wstrb),
      .o_ready   (o_ready),
      .o_rdata   (o_rdata)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1);
   endtask

   `include "int_mem_checks.svh"

   function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                         input strb_t strb);
      data_t result;
      result = old_word;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            result[b*8 +: 8] = new_word[b*8 +: 8];
         end
      end
      return result;
   endfunction

   task automatic check_pending();
      compare_flag("o_ready", o_ready, exp_ready);
      compare_flag("o_i_ready", o_i_ready, exp_i_ready);
      if (chk_rdata) begin
         compare_rdata(o_rdata, exp_rdata);
      end
      if (exp_i_ready) begin
         compare_data("o_i_data", o_i_data, exp_i_data);
      end
   endtask

   // one cycle: check the last request, then drive the next one
   task automatic step(input logic valid, input ram_addr_t addr, input data_t wdata,
                       input strb_t wstrb, input strb_t ien, input ram_addr_t iaddr);
      ram_addr_t offset;
      ram_addr_t phys;
      ram_addr_t iphys;
      logic      live;
      @(negedge clk);
      check_pending();
      live     = int_mem_i.boot_done;
      i_valid  = valid;
      i_addr   = addr;
      i_wdata  = wdata;
      i_wstrb  = wstrb;
      i_i_en   = ien;
      i_i_addr = iaddr;
      offset   = i_boot ? BOOT_BASE : '0;
      phys     = addr + offset;
      iphys    = iaddr + offset;
      // requests before done never reach the ram
      exp_ready   = valid && live;
      exp_i_ready = (ien != '0) && live;
      chk_rdata   = valid && live && (wstrb == '0);
      exp_rdata   = model[phys];
      // fetch sees the word from before a same-cycle write
      exp_i_data  = model[iphys];
      if (valid && live && (wstrb != '0)) begin
         model[phys] = merge_bytes(model[phys], wdata, wstrb);
      end
   endtask

   task automatic random_step();
      logic      valid;
      ram_addr_t addr;
      ram_addr_t iaddr;
      strb_t     wstrb;
      strb_t     ien;
      valid = ($urandom % 4) != 0;
      addr  = ram_addr_t'($urandom);
      wstrb = ($urandom % 2) ? strb_t'($urandom) : '0;
      ien   = ($urandom % 3) ? strb_t'($urandom) : '0;
      // same word on both ports now and then
      iaddr = ($urandom % 4) ? ram_addr_t'($urandom) : addr;
      step(valid, addr, data_t'($urandom), wstrb, ien, iaddr);
   endtask

   initial begin
      #((N_OPS * 4 + 100) * CLK_PERIOD);
      abort_run("watchdog expired before the test sequence finished");
   end

   initial begin
      int wait_cycles;
      rst         = 1'b1;
      i_boot      = 1'b1;
      i_valid     = 1'b0;
      i_addr      = '0;
      i_wdata     = '0;
      i_wstrb     = '0;
      i_i_en      = '0;
      i_i_addr    = '0;
      exp_ready   = 1'b0;
      exp_i_ready = 1'b0;
      chk_rdata   = 1'b0;
      exp_rdata   = '0;
      exp_i_data  = '0;
      void'($urandom(32'h4bf3));
      $readmemh("src/boot_rom.hex", rom_words);
      for (int a = 0; a < RAM_DEPTH; a++) begin
         model[a] = '0;
      end
      for (int k = 0; k < ROM_DEPTH; k++) begin
         model[int'(BOOT_BASE) + k] = rom_words[k];
      end

      repeat (5) step(1'b0, '0, '0, '0, '0, '0);
      rst = 1'b0;

      // copy phase, every request here must be dropped
      wait_cycles = 0;
      while (!int_mem_i.boot_done) begin
         if (wait_cycles > BOOT_LIMIT) begin
            abort_run("boot copy never finished, done did not rise");
         end
         random_step();
         wait_cycles++;
      end

      // clear the rest of the ram through the remapped window
      for (int a = ROM_DEPTH; a < RAM_DEPTH; a++) begin
         step(1'b1, ram_addr_t'(a), '0, '1, '0, '0);
      end

      for (int k = 0; k < ROM_DEPTH; k++) begin
         step(1'b1, ram_addr_t'(k), '0, '0, '1, ram_addr_t'(k));
      end

      repeat (N_RANDOM) random_step();

      // let the last remapped request land before boot drops
      step(1'b0, '0, '0, '0, '0, '0);

      // boot dropped, addresses pass through
      i_boot = 1'b0;
      for (int k = 0; k < ROM_DEPTH; k++) begin
         step(1'b1, BOOT_BASE + ram_addr_t'(k), '0, '0, '1, BOOT_BASE + ram_addr_t'(k));
      end

      repeat (N_LOW) random_step();
      step(1'b0, '0, '0, '0, '0, '0);

      $display("Test OK");
      $finish;
   end

endmodule

//--- src/boot_rom.hex
// boot rom image, one 32-bit word per line in hex, word 0 first
00400093
00800113
0c000193
f0f0a5a5
12345678
9abcdef0
00f00213
13579bdf
2468ace0
a5a55a5a
0ff00ff0
7e81c33c
c3d2e1f0
3ca5e10d
55aa33cc
80017fe3

//--- flist.f
+incdir+dv
src/int_mem_pkg.sv
src/mem_port_if.sv
src/boot_rom.sv
src/boot_copier.sv
src/dual_port_ram.sv
src/int_mem.sv
dv/int_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, and look for the pass message in the output
verilator --binary --timing --assert --top-module int_mem_tb -f flist.f -o int_mem_sim \
   && ./obj_dir/int_mem_sim | tee /dev/stderr | grep -q "Test OK" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
